// File: rv64_exu.f
exu_pkg.sv
axi_lite_pkg.sv
exu_regfile.sv
exu_alu.sv
exu_lsu.sv
exu_divider.sv
exu_step_counter.sv
exu_ctrl.sv
exu_top.sv
exu_checker.sv
exu_scoreboard.sv
tb_exu.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_exu \
    -f rv64_exu.f -o sim_exu
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_exu > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qF '** PASS **' sim.log; then
    exit 0
fi
exit 1

// File: tb_exu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exu import exu_pkg::*; import axi_lite_pkg::*; ();

    localparam int timeout_cycles = 200 * 90;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    logic      in_ready;
    uop_t      in_uop;
    logic      retire_valid;
    retire_t   retire;
    axil_req_t m_axi_req;
    axil_rsp_t rsp = '0;
    logic      exp_push;
    retire_t   exp_rec;
    op_e       exp_op;
    int        exp_test;
    int        exp_lat;
    int        errors;
    int        pending;
    int        cycles = 0;
    xlen_t     pc;
    xlen_t     rf_m [32];
    xlen_t     mem_m [256];
    xlen_t     mem [256];

    // memory model state
    axil_req_t req_s;
    logic      aw_got, w_got, ar_got;
    axi_addr_t aw_addr, ar_addr;
    axi_data_t w_data;
    axi_strb_t w_strb;
    int        aw_dly, w_dly, b_dly, ar_dly, r_dly;

    op_e alu_ops [11] = '{ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA, MUL};
    op_e br_ops [6]   = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};

    exu_top uut (
        .clk, .rst_n, .in_valid, .in_ready, .in_uop, .retire_valid, .retire,
        .m_axi_req, .m_axi_rsp(rsp)
    );

    exu_scoreboard sb (
        .clk, .rst_n, .in_valid, .in_ready, .retire_valid, .retire, .exp_push, .exp_rec,
        .exp_op, .exp_test, .exp_lat, .errors, .pending
    );

    bind exu_top exu_checker u_chk (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready),
        .retire_valid(retire_valid), .retire(retire), .m_axi_req(m_axi_req),
        .m_axi_rsp(m_axi_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout: no finish after %0d cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    // AXI4-Lite slave that samples at the edge and answers 1 ns later
    always @(posedge clk) begin
        req_s = m_axi_req;
        #1;
        if (!rst_n) begin
            rsp    = '0;
            aw_got = 1'b0;
            w_got  = 1'b0;
            ar_got = 1'b0;
            aw_dly = 0;
            w_dly  = 0;
            b_dly  = 0;
            ar_dly = 0;
            r_dly  = 0;
        end else begin
            if (req_s.awvalid && rsp.awready) begin
                aw_got      = 1'b1;
                aw_addr     = req_s.awaddr;
                rsp.awready = 1'b0;
            end else if (req_s.awvalid && !aw_got) begin
                if (aw_dly == 0) begin
                    rsp.awready = 1'b1;
                    aw_dly      = $urandom % 4;
                end else begin
                    aw_dly--;
                end
            end
            if (req_s.wvalid && rsp.wready) begin
                w_got      = 1'b1;
                w_data     = req_s.wdata;
                w_strb     = req_s.wstrb;
                rsp.wready = 1'b0;
            end else if (req_s.wvalid && !w_got) begin
                if (w_dly == 0) begin
                    rsp.wready = 1'b1;
                    w_dly      = $urandom % 4;
                end else begin
                    w_dly--;
                end
            end
            if (rsp.bvalid && req_s.bready) begin
                rsp.bvalid = 1'b0;
                aw_got     = 1'b0;
                w_got      = 1'b0;
            end else if (aw_got && w_got && !rsp.bvalid) begin
                if (b_dly == 0) begin
                    for (int k = 0; k < 8; k++) begin
                        if (w_strb[k]) mem[aw_addr[10:3]][k*8 +: 8] = w_data[k*8 +: 8];
                    end
                    rsp.bvalid = 1'b1;
                    rsp.bresp  = 2'b00;
                    b_dly      = $urandom % 4;
                end else begin
                    b_dly--;
                end
            end
            if (req_s.arvalid && rsp.arready) begin
                ar_got      = 1'b1;
                ar_addr     = req_s.araddr;
                rsp.arready = 1'b0;
            end else if (req_s.arvalid && !ar_got) begin
                if (ar_dly == 0) begin
                    rsp.arready = 1'b1;
                    ar_dly      = $urandom % 4;
                end else begin
                    ar_dly--;
                end
            end
            if (rsp.rvalid && req_s.rready) begin
                rsp.rvalid = 1'b0;
                ar_got     = 1'b0;
            end else if (ar_got && !rsp.rvalid) begin
                if (r_dly == 0) begin
                    rsp.rvalid = 1'b1;
                    rsp.rdata  = mem[ar_addr[10:3]];
                    rsp.rresp  = 2'b00;
                    r_dly      = $urandom % 4;
                end else begin
                    r_dly--;
                end
            end
        end
    end

    function automatic xlen_t rand64();
        return {$urandom, $urandom};
    endfunction

    function automatic int latency_of(op_e op);
        if (op inside {DIVU, REMU}) return div_steps + 3;
        if (op inside {LB, LH, LW, LD, LBU, LHU, LWU, SB, SH, SW, SD}) return -1;
        return 2;
    endfunction

    // expected retire from the architectural state before the instruction
    function automatic retire_t ref_exec(uop_t u);
        xlen_t   a;
        xlen_t   b;
        xlen_t   r2;
        xlen_t   ea;
        xlen_t   lane;
        xlen_t   y;
        logic    taken;
        logic    no_rd;
        retire_t r;
        a     = rf_m[u.rs1];
        r2    = rf_m[u.rs2];
        b     = u.use_imm ? u.imm : r2;
        ea    = a + u.imm;
        lane  = mem_m[ea[10:3]] >> (8 * ea[2:0]);
        y     = '0;
        taken = 1'b0;
        no_rd = u.op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU, SB, SH, SW, SD};
        r     = '0;
        r.pc   = u.pc;
        r.dnpc = u.pc + 64'd4;
        r.rd   = u.rd;
        r.we   = !no_rd && u.rd != 5'd0;
        case (u.op)
            ADD:   y = a + b;
            SUB:   y = a - b;
            AND:   y = a & b;
            OR:    y = a | b;
            XOR:   y = a ^ b;
            SLT:   y = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            SLTU:  y = (a < b) ? 64'd1 : 64'd0;
            SLL:   y = a << b[5:0];
            SRL:   y = a >> b[5:0];
            SRA:   y = xlen_t'($signed(a) >>> b[5:0]);
            MUL:   y = a * b;
            LUI:   y = u.imm;
            AUIPC: y = u.pc + u.imm;
            JAL: begin
                y      = u.pc + 64'd4;
                r.dnpc = u.pc + u.imm;
            end
            JALR: begin
                y      = u.pc + 64'd4;
                r.dnpc = ea & ~64'd1;
            end
            BEQ:   taken = a == r2;
            BNE:   taken = a != r2;
            BLT:   taken = $signed(a) < $signed(r2);
            BGE:   taken = $signed(a) >= $signed(r2);
            BLTU:  taken = a < r2;
            BGEU:  taken = a >= r2;
            DIVU:  y = (r2 == 0) ? '1 : a / r2;
            REMU:  y = (r2 == 0) ? a : a % r2;
            LB:    y = {{56{lane[7]}}, lane[7:0]};
            LH:    y = {{48{lane[15]}}, lane[15:0]};
            LW:    y = {{32{lane[31]}}, lane[31:0]};
            LD:    y = lane;
            LBU:   y = {56'd0, lane[7:0]};
            LHU:   y = {48'd0, lane[15:0]};
            LWU:   y = {32'd0, lane[31:0]};
            default: begin
                r.st_addr = ea;
                r.st_data = r2;
            end
        endcase
        if (taken) r.dnpc = u.pc + u.imm;
        r.wdata = y;
        return r;
    endfunction

    task automatic apply_model(input uop_t u, input retire_t r);
        int    n;
        xlen_t ba;
        n = (u.op == SB) ? 1 : (u.op == SH) ? 2 : (u.op == SW) ? 4 : 8;
        if (r.we) rf_m[r.rd] = r.wdata;
        if (u.op inside {SB, SH, SW, SD}) begin
            for (int k = 0; k < n; k++) begin
                ba = r.st_addr + xlen_t'(k);
                mem_m[ba[10:3]][8*ba[2:0] +: 8] = r.st_data[8*k +: 8];
            end
        end
    endtask

    task automatic issue(input op_e op, input logic use_imm, input int rd, input int rs1,
                         input int rs2, input xlen_t imm, input int test);
        uop_t    u;
        retire_t r;
        u = '{op: op, use_imm: use_imm, rd: reg_idx_t'(rd), rs1: reg_idx_t'(rs1),
              rs2: reg_idx_t'(rs2), imm: imm, pc: pc};
        r = ref_exec(u);
        while (!in_ready) begin
            @(posedge clk);
            #1;
        end
        in_uop   = u;
        in_valid = 1'b1;
        exp_push = 1'b1;
        exp_rec  = r;
        exp_op   = op;
        exp_test = test;
        exp_lat  = latency_of(op);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        exp_push = 1'b0;
        apply_model(u, r);
        pc = pc + 64'd4;
    endtask

    initial begin
        void'($urandom(46));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_uop   = '0;
        exp_push = 1'b0;
        exp_rec  = '0;
        exp_op   = ADD;
        exp_test = 0;
        exp_lat  = 0;
        pc       = 64'h1000;
        for (int i = 0; i < 32; i++) rf_m[i] = '0;
        // fill from the whole word address
        for (int i = 0; i < 256; i++) begin
            mem[i]   = {32'(i) * 32'h9e37_79b1, ~(32'(i) ^ 32'h5a5a_0000)};
            mem_m[i] = mem[i];
        end
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int i = 1; i < 32; i++) issue(LUI, 1'b1, i, 0, 0, rand64(), 1);
        for (int i = 0; i < 11; i++) begin
            issue(alu_ops[i], 1'b0, 11 + i, 1 + i, 12 + i, '0, 1);
            issue(alu_ops[i], 1'b1, 20 + i, 2 + i, 0, rand64(), 6);
        end
        issue(ADD, 1'b0, 0, 3, 4, '0, 1);
        issue(AUIPC, 1'b1, 9, 0, 0, 64'h7ff0, 1);

        for (int i = 0; i < 6; i++) begin
            issue(br_ops[i], 1'b0, 0, 1, 2, 64'h40, 2);
            issue(br_ops[i], 1'b0, 0, 3, 3, -64'sd24, 2);
        end
        issue(JAL, 1'b1, 1, 0, 0, 64'h100, 2);
        issue(JALR, 1'b1, 5, 4, 0, 64'd13, 2);
        issue(JALR, 1'b1, 0, 6, 0, -64'sd8, 2);

        issue(LUI, 1'b1, 7, 0, 0, 64'd7, 3);
        issue(DIVU, 1'b0, 8, 1, 2, '0, 3);
        issue(REMU, 1'b0, 9, 1, 2, '0, 3);
        issue(DIVU, 1'b0, 11, 2, 7, '0, 3);
        issue(REMU, 1'b0, 12, 2, 7, '0, 3);
        issue(DIVU, 1'b0, 13, 1, 0, '0, 3);
        issue(REMU, 1'b0, 14, 1, 0, '0, 3);

        // x10 is the base for the store and load words
        issue(LUI, 1'b1, 10, 0, 0, 64'h200, 4);
        for (int k = 0; k < 8; k++) issue(SB, 1'b1, 0, 10, 11 + k, xlen_t'(k), 4);
        for (int k = 0; k < 4; k++) issue(SH, 1'b1, 0, 10, 20 + k, xlen_t'(8 + 2 * k), 4);
        for (int k = 0; k < 2; k++) issue(SW, 1'b1, 0, 10, 25 + k, xlen_t'(16 + 4 * k), 4);
        issue(SD, 1'b1, 0, 10, 28, 64'd24, 4);
        for (int k = 0; k < 8; k++) begin
            issue(LB, 1'b1, 12 + k, 10, 0, xlen_t'(k), 4);
            issue(LBU, 1'b1, 12 + k, 10, 0, xlen_t'(k), 4);
        end
        for (int k = 0; k < 4; k++) begin
            issue(LH, 1'b1, 20 + k, 10, 0, xlen_t'(8 + 2 * k), 4);
            issue(LHU, 1'b1, 20 + k, 10, 0, xlen_t'(8 + 2 * k), 4);
        end
        for (int k = 0; k < 2; k++) begin
            issue(LW, 1'b1, 25 + k, 10, 0, xlen_t'(16 + 4 * k), 4);
            issue(LWU, 1'b1, 25 + k, 10, 0, xlen_t'(16 + 4 * k), 4);
        end
        issue(LD, 1'b1, 28, 10, 0, 64'd24, 4);
        for (int k = 0; k < 4; k++) begin
            issue(SD, 1'b1, 0, 10, 1 + k, xlen_t'(32 + 8 * k), 5);
            issue(LD, 1'b1, 29, 10, 0, xlen_t'(32 + 8 * k), 5);
        end

        while (!in_ready) begin
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);
        if (pending != 0) $display("%0d expected records still pending at the end", pending);
        $display("done: %0d check errors, %0d assertion failures, %0d records pending",
                 errors, uut.u_chk.fail_count, pending);
        if (errors == 0 && pending == 0 && uut.u_chk.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: exu_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module exu_scoreboard import exu_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    in_valid,
    input  wire logic    in_ready,
    input  wire logic    retire_valid,
    input  wire retire_t retire,
    input  wire logic    exp_push,
    input  wire retire_t exp_rec,
    input  wire op_e     exp_op,
    input  var  int      exp_test,
    input  var  int      exp_lat,
    output int           errors,
    output int           pending
);

    retire_t exp_q [$];
    op_e     op_q [$];
    int      test_q [$];
    int      lat_q [$];
    int      cyc;
    int      accept_cyc;
    int      cur_test;
    op_e     cur_op;
    retire_t e;
    int      lat;

    initial begin
        errors     = 0;
        pending    = 0;
        cyc        = 0;
        accept_cyc = 0;
    end

    task automatic check_field(input string field, input xlen_t exp_v, input xlen_t act_v);
        if (exp_v !== act_v) begin
            errors++;
            $display("MISMATCH test %0d %s %s: expected %h, actual %h",
                     cur_test, cur_op.name(), field, exp_v, act_v);
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (exp_push && in_valid && in_ready) begin
                exp_q.push_back(exp_rec);
                op_q.push_back(exp_op);
                test_q.push_back(exp_test);
                lat_q.push_back(exp_lat);
                accept_cyc = cyc;
            end
            if (retire_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("retire at pc %h arrived with no expected record", retire.pc);
                end else begin
                    e        = exp_q.pop_front();
                    cur_op   = op_q.pop_front();
                    cur_test = test_q.pop_front();
                    lat      = lat_q.pop_front();
                    check_field("pc", e.pc, retire.pc);
                    check_field("dnpc", e.dnpc, retire.dnpc);
                    check_field("rd", xlen_t'(e.rd), xlen_t'(retire.rd));
                    check_field("we", xlen_t'(e.we), xlen_t'(retire.we));
                    if (e.we) begin
                        check_field("wdata", e.wdata, retire.wdata);
                    end
                    check_field("st_addr", e.st_addr, retire.st_addr);
                    check_field("st_data", e.st_data, retire.st_data);
                    if (lat >= 0) begin
                        check_field("latency", xlen_t'(lat), xlen_t'(cyc - accept_cyc));
                    end
                end
            end
            pending = exp_q.size();
            cyc++;
        end
    end

endmodule

`default_nettype wire

// File: exu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module exu_checker import exu_pkg::*; import axi_lite_pkg::*; (
    input wire logic      clk,
    input wire logic      rst_n,
    input wire logic      in_valid,
    input wire logic      in_ready,
    input wire logic      retire_valid,
    input wire retire_t   retire,
    input wire axil_req_t m_axi_req,
    input wire axil_rsp_t m_axi_rsp
);

    int fail_count = 0;

    // a valid without its ready stays up with the same payload
    assert property (@(posedge clk) disable iff (!rst_n)
        m_axi_req.awvalid && !m_axi_rsp.awready |=>
            m_axi_req.awvalid && $stable(m_axi_req.awaddr))
        else begin
            $error("awvalid dropped or awaddr changed before awready");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        m_axi_req.wvalid && !m_axi_rsp.wready |=>
            m_axi_req.wvalid && $stable(m_axi_req.wdata) && $stable(m_axi_req.wstrb))
        else begin
            $error("wvalid dropped or write data changed before wready");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        m_axi_req.arvalid && !m_axi_rsp.arready |=>
            m_axi_req.arvalid && $stable(m_axi_req.araddr))
        else begin
            $error("arvalid dropped or araddr changed before arready");
            fail_count++;
        end

    // busy from acceptance through write-back
    assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && in_ready |=> !in_ready)
        else begin
            $error("in_ready high the cycle after acceptance");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_ready) |-> $past(retire_valid))
        else begin
            $error("in_ready rose without a retire in the cycle before");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |=> !retire_valid)
        else begin
            $error("retire_valid held longer than one cycle");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> !(retire.we && retire.rd == '0))
        else begin
            $error("retire reports a write to x0");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module exu_top import exu_pkg::*; import axi_lite_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    output logic      in_ready,
    input  uop_t      in_uop,
    output logic      retire_valid,
    output retire_t   retire,
    output axil_req_t m_axi_req,
    input  axil_rsp_t m_axi_rsp
);

    typedef struct packed {
        xlen_t result;
        xlen_t dnpc;
        xlen_t mem_addr;
    } exec_t;

    uop_t  uop_q;
    exec_t exec_q;
    logic  issue_q;
    logic  uop_load, cnt_load, div_start, div_step, lsu_start, rf_we;
    logic  last_step, mem_done;
    xlen_t rdata1, rdata2;
    xlen_t alu_result, alu_dnpc, alu_mem_addr;
    xlen_t quotient, remainder, load_value;
    xlen_t wb_data;

    exu_ctrl u_ctrl (
        .clk, .rst_n, .in_valid, .in_uop, .last_step, .mem_done,
        .in_ready, .uop_load, .cnt_load, .div_start, .div_step,
        .lsu_start, .rf_we, .retire_valid
    );

    exu_step_counter u_cnt (.clk, .rst_n, .load(cnt_load), .en(div_step), .last_step);

    exu_regfile u_rf (
        .clk, .rst_n, .rs1(uop_q.rs1), .rs2(uop_q.rs2), .rd(uop_q.rd),
        .we(rf_we), .wdata(wb_data), .rdata1, .rdata2
    );

    exu_alu u_alu (
        .uop(uop_q), .src1(rdata1), .src2(rdata2),
        .result(alu_result), .dnpc(alu_dnpc), .mem_addr(alu_mem_addr)
    );

    exu_divider u_div (
        .clk, .rst_n, .start(div_start), .step(div_step),
        .dividend(rdata1), .divisor(rdata2), .quotient, .remainder
    );

    exu_lsu u_lsu (
        .clk, .rst_n, .start(lsu_start), .op(uop_q.op), .addr(exec_q.mem_addr),
        .store_data(rdata2), .load_value, .mem_done, .m_axi_req, .m_axi_rsp
    );

    // the cycle after acceptance is always EXEC
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_q <= 1'b0;
        end else begin
            issue_q <= uop_load;
        end
    end

    always_ff @(posedge clk) begin
        if (uop_load) uop_q <= in_uop;
        if (issue_q) exec_q <= '{result: alu_result, dnpc: alu_dnpc, mem_addr: alu_mem_addr};
    end

    always_comb begin
        case (uop_q.op)
            DIVU:    wb_data = quotient;
            REMU:    wb_data = remainder;
            default: wb_data = is_load(uop_q.op) ? load_value : exec_q.result;
        endcase
    end

    always_comb begin
        retire       = '0;
        retire.pc    = uop_q.pc;
        retire.dnpc  = exec_q.dnpc;
        retire.rd    = uop_q.rd;
        retire.we    = rf_we && (uop_q.rd != '0);
        retire.wdata = wb_data;
        if (is_store(uop_q.op)) begin
            retire.st_addr = exec_q.mem_addr;
            retire.st_data = rdata2;
        end
    end

endmodule

`default_nettype wire

// File: exu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module exu_ctrl import exu_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    input  uop_t in_uop,
    input  logic last_step,
    input  logic mem_done,
    output logic in_ready,
    output logic uop_load,
    output logic cnt_load,
    output logic div_start,
    output logic div_step,
    output logic lsu_start,
    output logic rf_we,
    output logic retire_valid
);

    ctrl_state_e state;
    ctrl_state_e state_next;
    op_e         op_q;
    logic        div_first;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:     if (in_valid) state_next = EXEC;
            EXEC: begin
                if (is_div(op_q)) begin
                    state_next = DIV;
                end else if (is_load(op_q) || is_store(op_q)) begin
                    state_next = MEM_ADDR;
                end else begin
                    state_next = WB;
                end
            end
            DIV:      if (!div_first && last_step) state_next = WB;
            MEM_ADDR: state_next = MEM_RESP;
            MEM_RESP: if (mem_done) state_next = WB;
            default:  state_next = IDLE;
        endcase
    end

    // first DIV cycle captures operands, the rest are the 64 steps
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            div_first <= 1'b0;
        end else begin
            state     <= state_next;
            div_first <= (state == EXEC) && is_div(op_q);
        end
    end

    always_ff @(posedge clk) begin
        if (uop_load) begin
            op_q <= in_uop.op;
        end
    end

    assign in_ready     = (state == IDLE);
    assign uop_load     = in_valid && in_ready;
    assign cnt_load     = (state == DIV) && div_first;
    assign div_start    = (state == DIV) && div_first;
    assign div_step     = (state == DIV) && !div_first;
    assign lsu_start    = (state == MEM_ADDR);
    assign rf_we        = (state == WB) && !is_branch(op_q) && !is_store(op_q);
    assign retire_valid = (state == WB);

endmodule

`default_nettype wire

// File: exu_step_counter.sv
`timescale 1ns/1ps
`default_nettype none

module exu_step_counter import exu_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic load,
    input  logic en,
    output logic last_step
);

    step_cnt_t count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (load) begin
            count <= step_cnt_t'(div_steps - 1);
        end else if (en) begin
            count <= count - 1'b1;
        end
    end

    assign last_step = (count == '0);

endmodule

`default_nettype wire

// File: exu_divider.sv
`timescale 1ns/1ps
`default_nettype none

module exu_divider import exu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    input  logic  step,
    input  xlen_t dividend,
    input  xlen_t divisor,
    output xlen_t quotient,
    output xlen_t remainder
);

    xlen_t       quo_q;
    xlen_t       rem_q;
    xlen_t       dvs_q;
    logic [xlen:0] shifted;
    xlen_t       diff;
    logic        fits;

    // partial remainder needs one extra bit before the compare
    assign shifted = {rem_q, quo_q[xlen-1]};
    assign fits    = shifted >= {1'b0, dvs_q};
    // result is below the divisor whenever it is kept
    assign diff    = shifted[xlen-1:0] - dvs_q;

    // quo_q shifts dividend bits out the top and quotient bits in at the bottom
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            quo_q <= '0;
            rem_q <= '0;
            dvs_q <= '0;
        end else if (start) begin
            quo_q <= dividend;
            rem_q <= '0;
            dvs_q <= divisor;
        end else if (step) begin
            quo_q <= {quo_q[xlen-2:0], fits};
            rem_q <= fits ? diff : shifted[xlen-1:0];
        end
    end

    assign quotient  = quo_q;
    assign remainder = rem_q;

endmodule

`default_nettype wire

// File: exu_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module exu_lsu import exu_pkg::*; import axi_lite_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  op_e       op,
    input  xlen_t     addr,
    input  xlen_t     store_data,
    output xlen_t     load_value,
    output logic      mem_done,
    output axil_req_t m_axi_req,
    input  axil_rsp_t m_axi_rsp
);

    logic      aw_valid_q;
    logic      w_valid_q;
    logic      b_ready_q;
    logic      ar_valid_q;
    logic      r_ready_q;
    axi_addr_t addr_q;
    axi_data_t wdata_q;
    axi_strb_t strb_q;
    axi_data_t rdata_q;
    axi_strb_t strb_base;
    op_e       op_q;
    logic [2:0] off_q;
    xlen_t     lane;

    always_comb begin
        case (op)
            SB:      strb_base = 8'h01;
            SH:      strb_base = 8'h03;
            SW:      strb_base = 8'h0f;
            default: strb_base = 8'hff;
        endcase
    end

    // aw and w complete independently, b/r ready held until the response
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_valid_q <= 1'b0;
            w_valid_q  <= 1'b0;
            b_ready_q  <= 1'b0;
            ar_valid_q <= 1'b0;
            r_ready_q  <= 1'b0;
        end else if (start) begin
            aw_valid_q <= is_store(op);
            w_valid_q  <= is_store(op);
            b_ready_q  <= is_store(op);
            ar_valid_q <= is_load(op);
            r_ready_q  <= is_load(op);
        end else begin
            if (m_axi_rsp.awready) aw_valid_q <= 1'b0;
            if (m_axi_rsp.wready)  w_valid_q  <= 1'b0;
            if (m_axi_rsp.bvalid)  b_ready_q  <= 1'b0;
            if (m_axi_rsp.arready) ar_valid_q <= 1'b0;
            if (m_axi_rsp.rvalid)  r_ready_q  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q  <= {addr[xlen-1:3], 3'b000};
            wdata_q <= store_data << {addr[2:0], 3'b000};
            strb_q  <= strb_base << addr[2:0];
            off_q   <= addr[2:0];
            op_q    <= op;
        end
        if (r_ready_q && m_axi_rsp.rvalid) begin
            rdata_q <= m_axi_rsp.rdata;
        end
    end

    assign mem_done = (b_ready_q && m_axi_rsp.bvalid) || (r_ready_q && m_axi_rsp.rvalid);

    always_comb begin
        m_axi_req.awvalid = aw_valid_q;
        m_axi_req.awaddr  = addr_q;
        m_axi_req.wvalid  = w_valid_q;
        m_axi_req.wdata   = wdata_q;
        m_axi_req.wstrb   = strb_q;
        m_axi_req.bready  = b_ready_q;
        m_axi_req.arvalid = ar_valid_q;
        m_axi_req.araddr  = addr_q;
        m_axi_req.rready  = r_ready_q;
    end

    // move the addressed lane down to bit 0
    assign lane = rdata_q >> {off_q, 3'b000};

    always_comb begin
        case (op_q)
            LB:      load_value = {{56{lane[7]}}, lane[7:0]};
            LH:      load_value = {{48{lane[15]}}, lane[15:0]};
            LW:      load_value = {{32{lane[31]}}, lane[31:0]};
            LBU:     load_value = {56'b0, lane[7:0]};
            LHU:     load_value = {48'b0, lane[15:0]};
            LWU:     load_value = {32'b0, lane[31:0]};
            default: load_value = lane;
        endcase
    end

endmodule

`default_nettype wire

// File: exu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exu_alu import exu_pkg::*; (
    input  uop_t  uop,
    input  xlen_t src1,
    input  xlen_t src2,
    output xlen_t result,
    output xlen_t dnpc,
    output xlen_t mem_addr
);

    xlen_t      op_b;
    xlen_t      snpc;
    logic [5:0] shamt;
    logic       taken;

    assign op_b     = uop.use_imm ? uop.imm : src2;
    assign shamt    = op_b[5:0];
    assign snpc     = uop.pc + xlen_t'(4);
    assign mem_addr = src1 + uop.imm;

    always_comb begin
        case (uop.op)
            ADD:        result = src1 + op_b;
            SUB:        result = src1 - op_b;
            AND:        result = src1 & op_b;
            OR:         result = src1 | op_b;
            XOR:        result = src1 ^ op_b;
            SLT:        result = xlen_t'($signed(src1) < $signed(op_b));
            SLTU:       result = xlen_t'(src1 < op_b);
            SLL:        result = src1 << shamt;
            SRL:        result = src1 >> shamt;
            SRA:        result = xlen_t'($signed(src1) >>> shamt);
            MUL:        result = src1 * op_b;
            LUI:        result = uop.imm;
            AUIPC:      result = uop.pc + uop.imm;
            JAL, JALR:  result = snpc;
            default:    result = '0;
        endcase
    end

    // branches always compare the two registers
    always_comb begin
        case (uop.op)
            BEQ:     taken = (src1 == src2);
            BNE:     taken = (src1 != src2);
            BLT:     taken = ($signed(src1) < $signed(src2));
            BGE:     taken = ($signed(src1) >= $signed(src2));
            BLTU:    taken = (src1 < src2);
            BGEU:    taken = (src1 >= src2);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        dnpc = snpc;
        if (taken || uop.op == JAL) begin
            dnpc = uop.pc + uop.imm;
        end else if (uop.op == JALR) begin
            // jalr target is the same rs1+imm sum as the agu
            dnpc = {mem_addr[xlen-1:1], 1'b0};
        end
    end

endmodule

`default_nettype wire

// File: exu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module exu_regfile import exu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  logic     we,
    input  xlen_t    wdata,
    output xlen_t    rdata1,
    output xlen_t    rdata2
);

    xlen_t regs [32];

    // x0 is never written so it keeps its reset value of zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

`default_nettype wire

// File: axi_lite_pkg.sv
`default_nettype none

package axi_lite_pkg;

    typedef logic [63:0] axi_addr_t;
    typedef logic [63:0] axi_data_t;
    typedef logic [7:0]  axi_strb_t;
    typedef logic [1:0]  axi_resp_t;

    // master to slave
    typedef struct packed {
        logic      awvalid;
        axi_addr_t awaddr;
        logic      wvalid;
        axi_data_t wdata;
        axi_strb_t wstrb;
        logic      bready;
        logic      arvalid;
        axi_addr_t araddr;
        logic      rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic      awready;
        logic      wready;
        logic      bvalid;
        axi_resp_t bresp;
        logic      arready;
        logic      rvalid;
        axi_data_t rdata;
        axi_resp_t rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire

// File: exu_pkg.sv
`default_nettype none

package exu_pkg;

    localparam int xlen = 64;
    localparam int div_steps = 64;

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [$clog2(div_steps)-1:0] step_cnt_t;

    typedef enum logic [5:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA, MUL,
        LUI, AUIPC, JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LD, LBU, LHU, LWU,
        SB, SH, SW, SD,
        DIVU, REMU
    } op_e;

    typedef enum logic [2:0] {
        IDLE, EXEC, DIV, MEM_ADDR, MEM_RESP, WB
    } ctrl_state_e;

    // imm arrives already sign-extended from decode
    typedef struct packed {
        op_e      op;
        logic     use_imm;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        xlen_t    imm;
        xlen_t    pc;
    } uop_t;

    typedef struct packed {
        xlen_t    pc;
        xlen_t    dnpc;
        reg_idx_t rd;
        logic     we;
        xlen_t    wdata;
        xlen_t    st_addr;
        xlen_t    st_data;
    } retire_t;

    function automatic logic is_load(op_e op);
        return op inside {LB, LH, LW, LD, LBU, LHU, LWU};
    endfunction

    function automatic logic is_store(op_e op);
        return op inside {SB, SH, SW, SD};
    endfunction

    function automatic logic is_branch(op_e op);
        return op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU};
    endfunction

    function automatic logic is_div(op_e op);
        return op inside {DIVU, REMU};
    endfunction

endpackage

`default_nettype wire
